/* Makefile */
VERILATOR ?= verilator
TOP       ?= riscv_fd_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation reported an error, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/riscv_fd_cexpand.sv */
`timescale 1ns/1ps

module riscv_fd_cexpand (
    input  riscv_fd_pkg::fetch_item_t i_riscv_fd_item,
    output logic [31:0]               o_riscv_fd_inst
);
    import riscv_fd_pkg::*;

    logic [15:0] c;
    logic [4:0]  sel;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] imm_sx;
    logic [5:0]  shamt;
    logic [31:0] expanded;

    // Fields shared by the supported CI and CR formats.
    always_comb
    begin
        c      = i_riscv_fd_item.raw32[15:0];
        sel    = {c[15:13], c[1:0]};
        rd     = c[11:7];
        rs2    = c[6:2];
        imm_sx = {{6{c[12]}}, c[12], c[6:2]}; // Sign bit is inst[12].
        shamt  = {c[12], c[6:2]};             // RV64 allows a six bit shift.
    end

    always_comb
    begin
        expanded = 32'b0; // Unsupported encodings expand to zero.
        case (sel)
            RVC_Q1_ADDI:
            begin
                // addi rd, rd, imm.
                expanded = {imm_sx, rd, 3'b000, rd, OP_IMM};
            end
            RVC_Q1_LI:
            begin
                // addi rd, x0, imm.
                expanded = {imm_sx, 5'b00000, 3'b000, rd, OP_IMM};
            end
            RVC_Q2_SLLI:
            begin
                expanded = {6'b000000, shamt, rd, 3'b001, rd, OP_IMM};
            end
            RVC_Q2_MVADD:
            begin
                // rs2 of zero selects the jump and ebreak forms, not handled here.
                if (rs2 != 5'b00000)
                begin
                    if (c[12])
                    begin
                        expanded = {7'b0000000, rs2, rd, 3'b000, rd, OP};       // C.ADD.
                    end
                    else
                    begin
                        expanded = {7'b0000000, rs2, 5'b00000, 3'b000, rd, OP}; // C.MV.
                    end
                end
            end
            default:
            begin
                expanded = 32'b0;
            end
        endcase
    end

    // Full instructions pass through untouched.
    assign o_riscv_fd_inst = i_riscv_fd_item.compressed ? expanded : i_riscv_fd_item.raw32;

endmodule

/* logic/riscv_fd_fetch.sv */
`timescale 1ns/1ps

module riscv_fd_fetch #(
    parameter logic [63:0] RESET_PC = 64'h0
) (
    input  logic                      i_riscv_fd_clk,
    input  logic                      i_riscv_fd_rst,
    input  logic                      i_riscv_fd_redirect,
    input  logic [63:0]               i_riscv_fd_target,
    input  logic                      i_riscv_fd_ready,
    output riscv_fd_pkg::apb_req_t    o_riscv_fd_apb_req,
    input  riscv_fd_pkg::apb_rsp_t    i_riscv_fd_apb_rsp,
    output riscv_fd_pkg::fetch_item_t o_riscv_fd_item
);
    import riscv_fd_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SETUP  = 2'd1;
    localparam logic [1:0] ST_ACCESS = 2'd2;
    localparam logic [1:0] ST_VALID  = 2'd3; // Item waits for the pipeline register.

    logic [1:0]      state_q;
    logic [1:0]      state_d;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    logic            discard_q;              // Transfer in flight belongs to an old path.
    logic            discard_d;
    logic [31:0]     paddr_q;
    fetch_word_u     word_q;                 // Last fetched word, also serves the upper half.
    logic [15:0]     half;
    logic            item_c;
    logic            xfer_done;
    logic            fire;

    assign xfer_done = (state_q == ST_ACCESS) && i_riscv_fd_apb_rsp.pready;
    assign fire      = o_riscv_fd_item.valid && i_riscv_fd_ready;

    // Present the halfword or word that pc points at.
    always_comb
    begin
        half   = pc_q[1] ? word_q.half.c_hi : word_q.half.c_lo;
        item_c = pc_q[1] || (word_q.half.c_lo[1:0] != 2'b11);
        o_riscv_fd_item.valid      = (state_q == ST_VALID);
        o_riscv_fd_item.compressed = item_c;
        o_riscv_fd_item.pc         = pc_q;
        o_riscv_fd_item.pcnext     = pc_q + (item_c ? XLEN'(2) : XLEN'(4));
        o_riscv_fd_item.raw32      = item_c ? {16'b0, half} : word_q.raw;
    end

    always_comb
    begin
        o_riscv_fd_apb_req.paddr   = paddr_q;
        o_riscv_fd_apb_req.psel    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
        o_riscv_fd_apb_req.penable = (state_q == ST_ACCESS);
    end

    always_comb
    begin
        state_d   = state_q;
        pc_d      = pc_q;
        discard_d = discard_q;
        case (state_q)
            ST_IDLE:
            begin
                state_d = ST_SETUP;
            end
            ST_SETUP:
            begin
                state_d = ST_ACCESS; // Setup lasts exactly one cycle.
            end
            ST_ACCESS:
            begin
                if (i_riscv_fd_apb_rsp.pready)
                begin
                    // Stale data is dropped and the new pc is fetched.
                    state_d   = (discard_q || i_riscv_fd_redirect) ? ST_SETUP : ST_VALID;
                    discard_d = 1'b0;
                end
            end
            default:
            begin
                if (fire)
                begin
                    pc_d = o_riscv_fd_item.pcnext;
                    // A lower compressed half leaves the upper half in the buffer.
                    if (pc_q[1] || !item_c)
                    begin
                        state_d = ST_SETUP;
                    end
                end
            end
        endcase

        if (i_riscv_fd_redirect)
        begin
            pc_d = i_riscv_fd_target;
            if ((state_q == ST_SETUP) || ((state_q == ST_ACCESS) && !xfer_done))
            begin
                discard_d = 1'b1; // The transfer still runs to completion.
            end
            if ((state_q == ST_VALID) || (state_q == ST_IDLE))
            begin
                state_d = ST_SETUP; // Buffered word is no longer on the path.
            end
        end
    end

    always_ff @(posedge i_riscv_fd_clk or posedge i_riscv_fd_rst)
    begin
        if (i_riscv_fd_rst)
        begin
            state_q   <= ST_IDLE;
            pc_q      <= RESET_PC;
            discard_q <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            pc_q      <= pc_d;
            discard_q <= discard_d;
        end
    end

    // Address is captured once per transfer and held until pready.
    always_ff @(posedge i_riscv_fd_clk)
    begin
        if (state_d == ST_SETUP)
        begin
            paddr_q <= {pc_d[31:2], 2'b00};
        end
        if (xfer_done && !discard_q && !i_riscv_fd_redirect)
        begin
            word_q.raw <= i_riscv_fd_apb_rsp.prdata;
        end
    end

endmodule

/* logic/riscv_fd_frontend.sv */
`timescale 1ns/1ps

module riscv_fd_frontend #(
    parameter logic [63:0] RESET_PC = 64'h0 // Must be word aligned.
) (
    input  logic                   i_riscv_fd_clk,
    input  logic                   i_riscv_fd_rst,
    input  logic                   i_riscv_fd_stall,
    input  logic                   i_riscv_fd_redirect,
    input  logic [63:0]            i_riscv_fd_target,
    output riscv_fd_pkg::apb_req_t o_riscv_fd_apb_req,
    input  riscv_fd_pkg::apb_rsp_t i_riscv_fd_apb_rsp,
    output riscv_fd_pkg::fd_dec_t  o_riscv_fd_dec
);
    import riscv_fd_pkg::*;

    fetch_item_t     fetch_item;
    logic [ILEN-1:0] exp_inst;   // Expanded instruction for the current item.
    logic            pp_ready;

    riscv_fd_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .i_riscv_fd_clk      (i_riscv_fd_clk),
        .i_riscv_fd_rst      (i_riscv_fd_rst),
        .i_riscv_fd_redirect (i_riscv_fd_redirect),
        .i_riscv_fd_target   (i_riscv_fd_target),
        .i_riscv_fd_ready    (pp_ready),
        .o_riscv_fd_apb_req  (o_riscv_fd_apb_req),
        .i_riscv_fd_apb_rsp  (i_riscv_fd_apb_rsp),
        .o_riscv_fd_item     (fetch_item)
    );

    riscv_fd_cexpand u_cexpand (
        .i_riscv_fd_item (fetch_item),
        .o_riscv_fd_inst (exp_inst)
    );

    // A redirect flushes decode in the same cycle that fetch turns around.
    riscv_fd_ppreg u_ppreg (
        .i_riscv_fd_clk   (i_riscv_fd_clk),
        .i_riscv_fd_rst   (i_riscv_fd_rst),
        .i_riscv_fd_flush (i_riscv_fd_redirect),
        .i_riscv_fd_stall (i_riscv_fd_stall),
        .i_riscv_fd_item  (fetch_item),
        .i_riscv_fd_inst  (exp_inst),
        .o_riscv_fd_ready (pp_ready),
        .o_riscv_fd_dec   (o_riscv_fd_dec)
    );

endmodule

/* logic/riscv_fd_pkg.sv */
package riscv_fd_pkg;

    localparam int XLEN = 64; // Program counter width.
    localparam int ILEN = 32; // Instruction width.

    // Two compressed halfwords sharing one memory word.
    typedef struct packed {
        logic [15:0] c_hi; // Upper halfword, at pc + 2.
        logic [15:0] c_lo; // Lower halfword, at the word address.
    } fetch_half_t;

    // One memory word, seen as a full instruction or as two compressed ones.
    typedef union packed {
        logic [ILEN-1:0] raw;
        fetch_half_t     half;
    } fetch_word_u;

    // Item handed from fetch to the expander and the pipeline register.
    typedef struct packed {
        logic            valid;
        logic            compressed;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pcnext;
        logic [ILEN-1:0] raw32;      // Full word, or the halfword zero-extended.
    } fetch_item_t;

    // Decode stage view of one instruction.
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] inst;       // Expanded 32-bit instruction.
        logic [XLEN-1:0] pcnext;
        logic [4:0]      rs1;
        logic [11:0]     imm12;
        logic [15:0]     cinst;      // Original halfword, zero for full instructions.
    } fd_dec_t;

    // APB read request, driven by the fetch unit.
    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
    } apb_req_t;

    // APB read response, driven by the instruction memory.
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apb_rsp_t;

    // Compressed selectors, {funct3, quadrant}.
    localparam logic [4:0] RVC_Q1_ADDI  = 5'b000_01; // C.ADDI and C.NOP.
    localparam logic [4:0] RVC_Q1_LI    = 5'b010_01;
    localparam logic [4:0] RVC_Q2_SLLI  = 5'b000_10;
    localparam logic [4:0] RVC_Q2_MVADD = 5'b100_10; // Bit 12 picks C.ADD over C.MV.

    // Base opcodes produced by the expander.
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP     = 7'b0110011;

endpackage

/* logic/riscv_fd_ppreg.sv */
`timescale 1ns/1ps

module riscv_fd_ppreg (
    input  logic                      i_riscv_fd_clk,
    input  logic                      i_riscv_fd_rst,
    input  logic                      i_riscv_fd_flush,
    input  logic                      i_riscv_fd_stall,
    input  riscv_fd_pkg::fetch_item_t i_riscv_fd_item,
    input  logic [31:0]               i_riscv_fd_inst,
    output logic                      o_riscv_fd_ready,
    output riscv_fd_pkg::fd_dec_t     o_riscv_fd_dec
);
    import riscv_fd_pkg::*;

    fd_dec_t dec_load;

    // Next decode entry, a bubble when fetch has nothing.
    always_comb
    begin
        dec_load = '0;
        if (i_riscv_fd_item.valid)
        begin
            dec_load.valid  = 1'b1;
            dec_load.pc     = i_riscv_fd_item.pc;
            dec_load.inst   = i_riscv_fd_inst;
            dec_load.pcnext = i_riscv_fd_item.pcnext;
            dec_load.rs1    = i_riscv_fd_inst[19:15];
            dec_load.imm12  = i_riscv_fd_inst[31:20];
            if (i_riscv_fd_item.compressed)
            begin
                dec_load.cinst = i_riscv_fd_item.raw32[15:0]; // Trace of the original halfword.
            end
        end
    end

    always_ff @(posedge i_riscv_fd_clk or posedge i_riscv_fd_rst)
    begin
        if (i_riscv_fd_rst)
        begin
            o_riscv_fd_dec <= '0;
        end
        else if (i_riscv_fd_flush)
        begin
            o_riscv_fd_dec <= '0; // Flush wins over stall.
        end
        else if (!i_riscv_fd_stall)
        begin
            o_riscv_fd_dec <= dec_load;
        end
    end

    // Fetch may hand over its item only when this register will take it.
    assign o_riscv_fd_ready = ~(i_riscv_fd_stall | i_riscv_fd_flush);

endmodule

/* sim.f */
logic/riscv_fd_pkg.sv
logic/riscv_fd_fetch.sv
logic/riscv_fd_cexpand.sv
logic/riscv_fd_ppreg.sv
logic/riscv_fd_frontend.sv
tb/riscv_fd_apb_mem.sv
tb/riscv_fd_tb.sv

/* tb/riscv_fd_apb_mem.sv */
`timescale 1ns/1ps

module riscv_fd_apb_mem #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic                   i_riscv_fd_clk,
    input  logic                   i_riscv_fd_rst,
    input  riscv_fd_pkg::apb_req_t i_riscv_fd_apb_req,
    output riscv_fd_pkg::apb_rsp_t o_riscv_fd_apb_rsp
);
    import riscv_fd_pkg::*;

    logic [31:0] mem [0:255]; // Program image, also walked by the testbench model.
    logic [1:0]  wait_q;      // Wait states left in the current access.
    logic        ready_c;
    integer      seed;

    // One supported compressed instruction, picked at random.
    function automatic logic [15:0] random_rvc();
        logic [31:0] rnd;
        logic [4:0]  rs2;
        rnd = $random(seed);
        rs2 = (rnd[6:2] == 5'd0) ? 5'd1 : rnd[6:2]; // C.MV and C.ADD need a nonzero rs2.
        case (rnd[18:16])
            3'd0: return {3'b000, rnd[12], rnd[11:7], rnd[6:2], 2'b01}; // C.ADDI.
            3'd1: return {3'b010, rnd[12], rnd[11:7], rnd[6:2], 2'b01}; // C.LI.
            3'd2: return {3'b000, rnd[12], rnd[11:7], rnd[6:2], 2'b10}; // C.SLLI.
            3'd3: return {3'b100, 1'b0, rnd[11:7], rs2, 2'b10};          // C.MV.
            3'd4: return {3'b100, 1'b1, rnd[11:7], rs2, 2'b10};          // C.ADD.
            default: return 16'h0001;                                     // C.NOP.
        endcase
    endfunction

    // Full I-type and R-type words, or a pair of compressed halfwords.
    initial
    begin
        logic [31:0] rnd;
        seed = SEED;
        for (int i = 0; i < 256; i++)
        begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0: mem[i] = {rnd[31:20], rnd[19:15], rnd[14:12], rnd[11:7], OP_IMM};
                2'd1: mem[i] = {7'b0000000, rnd[24:20], rnd[19:15], rnd[14:12], rnd[11:7], OP};
                default: mem[i] = {random_rvc(), random_rvc()};
            endcase
        end
    end

    always @(posedge i_riscv_fd_clk or posedge i_riscv_fd_rst)
    begin
        logic [31:0] ws_rand;
        if (i_riscv_fd_rst)
        begin
            wait_q <= 2'd0;
        end
        else if (i_riscv_fd_apb_req.psel && !i_riscv_fd_apb_req.penable)
        begin
            ws_rand = $random(seed);
            wait_q  <= ws_rand[1:0]; // 0 to 3 wait states.
        end
        else if (i_riscv_fd_apb_req.penable && (wait_q != 2'd0))
        begin
            wait_q <= wait_q - 2'd1;
        end
    end

    assign ready_c = i_riscv_fd_apb_req.psel && i_riscv_fd_apb_req.penable && (wait_q == 2'd0);
    assign o_riscv_fd_apb_rsp.pready = ready_c;
    assign o_riscv_fd_apb_rsp.prdata = ready_c ? mem[i_riscv_fd_apb_req.paddr[9:2]] : 32'h0;

endmodule

/* tb/riscv_fd_tb.sv */
`timescale 1ns/1ps

module riscv_fd_tb;
    import riscv_fd_pkg::*;

    localparam logic [31:0] SEED       = 32'h86151e57;
    localparam int          NUM_CYCLES = 4000;
    localparam int          IDLE_LIMIT = 200; // Cycles allowed without a new decode item.
    localparam int          MIN_ITEMS  = 300;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        redirect;
    logic [63:0] target;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    fd_dec_t     dec;
    fd_dec_t     prev_dec;   // Decode output one cycle earlier.
    integer      seed;
    logic [31:0] rnd;
    logic [63:0] model_pc;
    logic        xfer_open;  // Setup seen, pready not yet.
    logic [31:0] xfer_addr;
    logic        drop_next;  // Next completion belongs to an abandoned path.
    int          good_xfers;
    int          words_seen;
    int          items;
    int          idle;

    riscv_fd_frontend #(.RESET_PC(64'h0)) dut0 (
        .i_riscv_fd_clk      (clk),
        .i_riscv_fd_rst      (rst),
        .i_riscv_fd_stall    (stall),
        .i_riscv_fd_redirect (redirect),
        .i_riscv_fd_target   (target),
        .o_riscv_fd_apb_req  (apb_req),
        .i_riscv_fd_apb_rsp  (apb_rsp),
        .o_riscv_fd_dec      (dec)
    );

    riscv_fd_apb_mem #(.SEED(SEED)) mem0 (
        .i_riscv_fd_clk     (clk),
        .i_riscv_fd_rst     (rst),
        .i_riscv_fd_apb_req (apb_req),
        .o_riscv_fd_apb_rsp (apb_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("FAILED at %0t ns: %s is 'h%0h, expected 'h%0h", $time, name, got, exp);
        abort_run();
    endtask

    // RVC expansion rules for the supported subset.
    function automatic logic [31:0] expand_rvc(input logic [15:0] h);
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        imm = {{7{h[12]}}, h[6:2]};
        rd  = h[11:7];
        rs2 = h[6:2];
        case ({h[1:0], h[15:13]})
            5'b01_000: return {imm, rd, 3'b000, rd, 7'h13};          // addi rd, rd, imm.
            5'b01_010: return {imm, 5'd0, 3'b000, rd, 7'h13};        // addi rd, x0, imm.
            5'b10_000: return {6'd0, h[12], rs2, rd, 3'b001, rd, 7'h13};
            5'b10_100:
            begin
                if (rs2 == 5'd0)
                    return 32'h0;
                if (h[12])
                    return {7'd0, rs2, rd, 3'b000, rd, 7'h33};       // add rd, rd, rs2.
                return {7'd0, rs2, 5'd0, 3'b000, rd, 7'h33};         // add rd, x0, rs2.
            end
            default: return 32'h0;
        endcase
    endfunction

    // Compare a newly loaded decode entry with the model, then step the model.
    task automatic check_item();
        logic [31:0] word;
        logic [15:0] half;
        logic        comp;
        logic [31:0] exp_inst;
        logic [63:0] exp_next;
        word     = mem0.mem[model_pc[9:2]];
        half     = model_pc[1] ? word[31:16] : word[15:0];
        comp     = model_pc[1] || (word[1:0] != 2'b11);
        exp_inst = comp ? expand_rvc(half) : word;
        exp_next = model_pc + (comp ? 64'd2 : 64'd4);
        if (!model_pc[1])
            words_seen++;
        items++;
        assert (dec.pc == model_pc) else report_value("o_riscv_fd_dec.pc", dec.pc, model_pc);
        assert (dec.pcnext == exp_next)
            else report_value("o_riscv_fd_dec.pcnext", dec.pcnext, exp_next);
        assert (dec.inst == exp_inst)
            else report_value("o_riscv_fd_dec.inst", 64'(dec.inst), 64'(exp_inst));
        assert (dec.rs1 == exp_inst[19:15])
            else report_value("o_riscv_fd_dec.rs1", 64'(dec.rs1), 64'(exp_inst[19:15]));
        assert (dec.imm12 == exp_inst[31:20])
            else report_value("o_riscv_fd_dec.imm12", 64'(dec.imm12), 64'(exp_inst[31:20]));
        assert (dec.cinst == (comp ? half : 16'h0))
            else report_value("o_riscv_fd_dec.cinst", 64'(dec.cinst), 64'(comp ? half : 16'h0));
        assert (good_xfers == words_seen)
            else report_value("APB transfer count", 64'(good_xfers), 64'(words_seen));
        model_pc = exp_next;
    endtask

    // APB protocol checks and transfer counting for the coming rising edge.
    task automatic watch_apb();
        if (apb_req.psel && !apb_req.penable)
        begin
            assert (!xfer_open) else
            begin
                $display("APB setup at %0t ns before the previous transfer ended", $time);
                abort_run();
            end
            // A new read always targets the word holding the next predicted pc.
            assert (apb_req.paddr == {model_pc[31:2], 2'b00})
                else report_value("o_riscv_fd_apb_req.paddr", 64'(apb_req.paddr),
                                  64'({model_pc[31:2], 2'b00}));
            xfer_open = 1'b1;
            xfer_addr = apb_req.paddr;
            if (redirect)
                drop_next = 1'b1;
        end
        else if (apb_req.penable)
        begin
            assert (xfer_open && apb_req.psel) else
            begin
                $display("penable high at %0t ns without a preceding setup cycle", $time);
                abort_run();
            end
            assert (apb_req.paddr == xfer_addr)
                else report_value("o_riscv_fd_apb_req.paddr", 64'(apb_req.paddr), 64'(xfer_addr));
            if (apb_rsp.pready)
            begin
                xfer_open = 1'b0;
                if (drop_next || redirect)
                    drop_next = 1'b0;
                else
                    good_xfers++;
            end
            else if (redirect)
                drop_next = 1'b1;
        end
        else
        begin
            assert (!xfer_open) else
            begin
                $display("APB transfer abandoned before pready at %0t ns", $time);
                abort_run();
            end
        end
    endtask

    initial
    begin
        seed       = SEED;
        rst        = 1'b1;
        stall      = 1'b0;
        redirect   = 1'b0;
        target     = 64'h0;
        xfer_open  = 1'b0;
        xfer_addr  = 32'h0;
        drop_next  = 1'b0;
        good_xfers = 0;
        words_seen = 0;
        items      = 0;
        idle       = 0;
        model_pc   = 64'h0;
        #1;
        assert ({apb_req.psel, apb_req.penable} == 2'b00)
            else report_value("o_riscv_fd_apb_req.psel/penable",
                              64'({apb_req.psel, apb_req.penable}), 64'h0);
        assert (dec == '0) else
        begin
            $display("FAILED at %0t ns: o_riscv_fd_dec is 'h%0h, expected 'h0", $time, dec);
            abort_run();
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        prev_dec = dec;

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
        begin
            @(negedge clk);
            idle++;
            if (redirect)                                     // Flush at the last edge.
            begin
                assert (dec.valid == 1'b0)
                    else report_value("o_riscv_fd_dec.valid", 64'(dec.valid), 64'h0);
            end
            else if (stall)
            begin
                assert (dec == prev_dec) else
                begin
                    $display("FAILED at %0t ns: o_riscv_fd_dec is 'h%0h, expected 'h%0h",
                             $time, dec, prev_dec);
                    abort_run();
                end
            end
            else if (dec.valid)
            begin
                check_item();
                idle = 0;
            end
            assert (idle < IDLE_LIMIT) else
            begin
                $display("Timeout, no new decode item within %0d cycles", IDLE_LIMIT);
                abort_run();
            end
            rnd      = $random(seed);
            stall    = (rnd[1:0] == 2'b00);                   // About a quarter of cycles.
            redirect = (rnd[17:8] < 10'd26);                  // Roughly one in forty.
            target   = {54'd0, rnd[31:24], 2'b00};
            watch_apb();
            if (redirect)
            begin
                model_pc   = target;
                words_seen = 0;
                good_xfers = 0;
            end
            prev_dec = dec;
        end

        if (items < MIN_ITEMS)
        begin
            $display("Only %0d decode items were checked", items);
            abort_run();
        end
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
